// File: Makefile
# Verilator build for the jump path testbench.

VERILATOR ?= verilator
TOP       ?= jumpCoreTb
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= All tests passed!

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) source/*.sv test/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: source/cpuPkg.sv
`default_nettype none

package cpuPkg;

	typedef logic [15:0] wordType; // data or address word.

	// group 2 word layout.
	typedef struct packed {
		logic [1:0] groupF;
		logic [1:0] skipF;  // 0x always, 10 on cc, 11 on !cc.
		logic [1:0] ccF;
		logic [1:0] jpF;
		logic       jlF;    // link into register A.
		logic [2:0] spare;
		logic [3:0] argB;
	} instrType;

	typedef struct packed {
		logic zero;
		logic carry;
		logic sign;
		logic parity;
	} flagsType;

	// one-hot instruction phase.
	typedef struct packed {
		logic fetch;
		logic decode;
		logic execute;
		logic commit;
	} phaseType;

	localparam phaseType PHASE_FETCH = '{fetch: 1'b1, decode: 1'b0, execute: 1'b0, commit: 1'b0};

	localparam logic [1:0] GROUP_JUMP = 2'b10;

	// pc offset select.
	localparam logic [1:0] OFFSET_0   = 2'd0;
	localparam logic [1:0] OFFSET_2   = 2'd1;
	localparam logic [1:0] OFFSET_4   = 2'd2;
	localparam logic [1:0] OFFSET_DIN = 2'd3;

	// pc base select, code 3 unused.
	localparam logic [1:0] BASE_0    = 2'd0;
	localparam logic [1:0] BASE_PC   = 2'd1;
	localparam logic [1:0] BASE_REGB = 2'd2;

	localparam logic [1:0] ADDR_PC   = 2'd0; // bus carries pc.
	localparam logic [1:0] ADDR_HERE = 2'd1; // bus carries the inline word address.

	localparam logic [1:0] CC_Z = 2'd0;
	localparam logic [1:0] CC_C = 2'd1;
	localparam logic [1:0] CC_S = 2'd2;
	localparam logic [1:0] CC_P = 2'd3;

	localparam logic [1:0] JMP_ABS_REG  = 2'd0; // jp rb.
	localparam logic [1:0] JMP_IND_REG  = 2'd1; // jp (rb).
	localparam logic [1:0] JMP_ABS_HERE = 2'd2; // jp s16.
	localparam logic [1:0] JMP_REL_HERE = 2'd3; // jr s16.

	localparam logic [1:0] REGA_DIN_HERE  = 2'd0;
	localparam logic [1:0] REGA_ADDR_RL   = 2'd0;
	localparam logic [2:0] REGB_ADDR_ARGB = 3'd0;
	localparam logic [2:0] REGB_ADDR_RB   = 3'd1;

	localparam logic [2:0] ALUB_REGB = 3'd0;
	localparam logic [2:0] ALUB_S8   = 3'd1;
	localparam logic [2:0] ALUB_U8H  = 3'd2;

	typedef struct packed {
		logic [1:0] pcOffsetX;
		logic [1:0] pcBaseX;
		logic [1:0] addrBusX;
	} pcCtrlType;

	typedef struct packed {
		logic [1:0] regADinX;
		logic [1:0] regAAddrX;
		logic [2:0] regBAddrX;
		logic       regAEn;
		logic       regAWen;
		logic       regBEn;
		logic [2:0] aluBSrcX;
	} regCtrlType;

endpackage

`default_nettype wire

// File: source/jumpCore.sv
`default_nettype none
`timescale 1ns/100ps

module jumpCore (
	input  logic               CLK,
	input  logic               RESET,
	input  cpuPkg::instrType   instrIn,
	input  cpuPkg::flagsType   flags,
	input  cpuPkg::wordType    din,
	input  cpuPkg::wordType    regBDout,
	output cpuPkg::wordType    pc,
	output cpuPkg::phaseType   phase,
	output logic [1:0]         addrBusX,
	output cpuPkg::regCtrlType regCtrl,
	output logic               rdx
);

	cpuPkg::instrType   instr;
	cpuPkg::pcCtrlType  pcCtrlRaw;
	cpuPkg::regCtrlType regCtrlRaw;
	cpuPkg::pcCtrlType  pcCtrl;

	assign addrBusX = pcCtrl.addrBusX;

	phaseSequencer sequencer0 (
		.CLK     (CLK),
		.RESET   (RESET),
		.instrIn (instrIn),
		.phase   (phase),
		.instr   (instr)
	);

	jumpGroupDecoder decoder0 (
		.CLK        (CLK),
		.RESET      (RESET),
		.decode     (phase.decode),
		.execute    (phase.execute),
		.commit     (phase.commit),
		.instr      (instr),
		.flags      (flags),
		.pcCtrlRaw  (pcCtrlRaw),
		.regCtrlRaw (regCtrlRaw),
		.rdx        (rdx)
	);

	opxMultiplexer opx0 (
		.phase      (phase),
		.groupF     (instr.groupF),
		.pcCtrlRaw  (pcCtrlRaw),
		.regCtrlRaw (regCtrlRaw),
		.pcCtrl     (pcCtrl),
		.regCtrl    (regCtrl)
	);

	programCounter pc0 (
		.CLK      (CLK),
		.RESET    (RESET),
		.commit   (phase.commit),
		.pcCtrl   (pcCtrl),
		.din      (din),
		.regBDout (regBDout),
		.pc       (pc)
	);

endmodule

`default_nettype wire

// File: source/jumpGroupDecoder.sv
`default_nettype none
`timescale 1ns/100ps

module jumpGroupDecoder (
	input  logic               CLK,
	input  logic               RESET,
	input  logic               decode,
	input  logic               execute,
	input  logic               commit,
	input  cpuPkg::instrType   instr,
	input  cpuPkg::flagsType   flags,
	output cpuPkg::pcCtrlType  pcCtrlRaw,
	output cpuPkg::regCtrlType regCtrlRaw,
	output logic               rdx
);

	logic cc;
	logic taken;
	logic rdMem; // mode fetches an inline word.

	// condition flag and skip rule.
	always_comb begin
		case (instr.ccF)
			cpuPkg::CC_Z: cc = flags.zero;
			cpuPkg::CC_C: cc = flags.carry;
			cpuPkg::CC_S: cc = flags.sign;
			cpuPkg::CC_P: cc = flags.parity;
		endcase

		// skipF[1] clear jumps regardless of cc.
		taken = ~instr.skipF[1] | (instr.skipF[0] ? ~cc : cc);
	end

	// pc and address selects, used by the mux during commit only.
	always_comb begin
		if (taken) begin
			case (instr.jpF)
				cpuPkg::JMP_ABS_REG: begin
					pcCtrlRaw.pcOffsetX = cpuPkg::OFFSET_0;
					pcCtrlRaw.pcBaseX   = cpuPkg::BASE_REGB;
					pcCtrlRaw.addrBusX  = cpuPkg::ADDR_PC;
				end

				cpuPkg::JMP_IND_REG: begin
					pcCtrlRaw.pcOffsetX = cpuPkg::OFFSET_DIN; // target read through rb.
					pcCtrlRaw.pcBaseX   = cpuPkg::BASE_0;
					pcCtrlRaw.addrBusX  = cpuPkg::ADDR_PC;
				end

				cpuPkg::JMP_ABS_HERE: begin
					pcCtrlRaw.pcOffsetX = cpuPkg::OFFSET_DIN;
					pcCtrlRaw.pcBaseX   = cpuPkg::BASE_0;
					pcCtrlRaw.addrBusX  = cpuPkg::ADDR_HERE;
				end

				cpuPkg::JMP_REL_HERE: begin
					pcCtrlRaw.pcOffsetX = cpuPkg::OFFSET_DIN;
					pcCtrlRaw.pcBaseX   = cpuPkg::BASE_PC; // displacement from pc.
					pcCtrlRaw.addrBusX  = cpuPkg::ADDR_HERE;
				end
			endcase
		end else begin
			pcCtrlRaw.pcBaseX  = cpuPkg::BASE_PC;
			pcCtrlRaw.addrBusX = cpuPkg::ADDR_PC;

			// skip over the inline word for the here modes.
			case (instr.jpF)
				cpuPkg::JMP_ABS_REG:  pcCtrlRaw.pcOffsetX = cpuPkg::OFFSET_2;
				cpuPkg::JMP_IND_REG:  pcCtrlRaw.pcOffsetX = cpuPkg::OFFSET_2;
				cpuPkg::JMP_ABS_HERE: pcCtrlRaw.pcOffsetX = cpuPkg::OFFSET_4;
				cpuPkg::JMP_REL_HERE: pcCtrlRaw.pcOffsetX = cpuPkg::OFFSET_4;
			endcase
		end
	end

	// register file, alu source and read demand.
	always_comb begin
		regCtrlRaw.regADinX  = cpuPkg::REGA_DIN_HERE;
		regCtrlRaw.regAAddrX = cpuPkg::REGA_ADDR_RL;
		regCtrlRaw.regBAddrX = cpuPkg::REGB_ADDR_ARGB;
		regCtrlRaw.aluBSrcX  = cpuPkg::ALUB_REGB;
		regCtrlRaw.regBEn    = 1'b0;
		rdMem                = 1'b0;

		// link writes the return address, taken or not.
		regCtrlRaw.regAEn  = instr.jlF;
		regCtrlRaw.regAWen = instr.jlF;

		case (instr.jpF)
			cpuPkg::JMP_ABS_REG: begin
				regCtrlRaw.regBEn = 1'b1;
			end

			cpuPkg::JMP_IND_REG: begin
				regCtrlRaw.aluBSrcX = cpuPkg::ALUB_S8;
				regCtrlRaw.regBEn   = 1'b1;
			end

			cpuPkg::JMP_ABS_HERE: begin
				rdMem = 1'b1;
			end

			cpuPkg::JMP_REL_HERE: begin
				regCtrlRaw.aluBSrcX  = cpuPkg::ALUB_U8H;
				regCtrlRaw.regBAddrX = cpuPkg::REGB_ADDR_RB;
				regCtrlRaw.regBEn    = 1'b1;
				rdMem                = 1'b1;
			end
		endcase
	end

	// read strobe covers execute, commit and the next fetch.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			rdx <= 1'b0;
		end else if (decode || execute || commit) begin
			rdx <= rdMem;
		end else begin
			rdx <= 1'b0; // end of fetch.
		end
	end

	// strobe starts in execute and never shows in decode, reading modes only.
	assert property (@(posedge CLK) disable iff (RESET)
		rdx |-> (rdMem && !decode && (execute || $past(rdx))))
		else $error("rdx high outside its read window.");

endmodule

`default_nettype wire

// File: source/opxMultiplexer.sv
`default_nettype none
`timescale 1ns/100ps

module opxMultiplexer (
	input  cpuPkg::phaseType   phase,
	input  logic [1:0]         groupF,
	input  cpuPkg::pcCtrlType  pcCtrlRaw,
	input  cpuPkg::regCtrlType regCtrlRaw,
	output cpuPkg::pcCtrlType  pcCtrl,
	output cpuPkg::regCtrlType regCtrl
);

	logic jumpCommit;

	assign jumpCommit = phase.commit && (groupF == cpuPkg::GROUP_JUMP);

	always_comb begin
		// plain step of two bytes.
		pcCtrl.pcOffsetX = cpuPkg::OFFSET_2;
		pcCtrl.pcBaseX   = cpuPkg::BASE_PC;
		pcCtrl.addrBusX  = cpuPkg::ADDR_PC;

		regCtrl.regADinX  = cpuPkg::REGA_DIN_HERE;
		regCtrl.regAAddrX = cpuPkg::REGA_ADDR_RL;
		regCtrl.regBAddrX = cpuPkg::REGB_ADDR_ARGB;
		regCtrl.aluBSrcX  = cpuPkg::ALUB_REGB;
		regCtrl.regAEn    = 1'b0; // enables idle outside commit.
		regCtrl.regAWen   = 1'b0;
		regCtrl.regBEn    = 1'b0;

		if (jumpCommit) begin
			pcCtrl  = pcCtrlRaw;
			regCtrl = regCtrlRaw;
		end

		// a link write needs its port enabled in commit.
		assert (!regCtrl.regAWen || (phase.commit && regCtrl.regAEn))
			else $error("regAWen outside commit or without regAEn.");
	end

endmodule

`default_nettype wire

// File: source/phaseSequencer.sv
`default_nettype none
`timescale 1ns/100ps

module phaseSequencer (
	input  logic             CLK,
	input  logic             RESET,
	input  cpuPkg::instrType instrIn,
	output cpuPkg::phaseType phase,
	output cpuPkg::instrType instr
);

	// ring steps fetch, decode, execute, commit.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			phase <= cpuPkg::PHASE_FETCH;
		end else begin
			phase.fetch   <= phase.commit;
			phase.decode  <= phase.fetch;
			phase.execute <= phase.decode;
			phase.commit  <= phase.execute;
		end
	end

	// instruction register, loaded as fetch ends.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			instr <= '0;
		end else if (phase.fetch) begin
			instr <= instrIn;
		end
	end

	// ring must never lose or duplicate its token.
	assert property (@(posedge CLK) disable iff (RESET) $onehot(phase))
		else $error("phase ring not one-hot.");

endmodule

`default_nettype wire

// File: source/programCounter.sv
`default_nettype none
`timescale 1ns/100ps

module programCounter (
	input  logic              CLK,
	input  logic              RESET,
	input  logic              commit,
	input  cpuPkg::pcCtrlType pcCtrl,
	input  cpuPkg::wordType   din,
	input  cpuPkg::wordType   regBDout,
	output cpuPkg::wordType   pc
);

	cpuPkg::wordType base;
	cpuPkg::wordType offset;
	cpuPkg::wordType sum;

	always_comb begin
		case (pcCtrl.pcBaseX)
			cpuPkg::BASE_PC:   base = pc;
			cpuPkg::BASE_REGB: base = regBDout;
			default:           base = '0; // BASE_0 and the spare code.
		endcase

		case (pcCtrl.pcOffsetX)
			cpuPkg::OFFSET_0: offset = 16'd0;
			cpuPkg::OFFSET_2: offset = 16'd2;
			cpuPkg::OFFSET_4: offset = 16'd4;
			default:          offset = din;
		endcase
	end

	assign sum = base + offset;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			pc <= '0;
		end else if (commit) begin
			pc <= sum; // next instruction address.
		end
	end

	// a constant step runs from an even pc.
	assert property (@(posedge CLK) disable iff (RESET)
		(commit && pcCtrl.pcBaseX == cpuPkg::BASE_PC
			&& pcCtrl.pcOffsetX != cpuPkg::OFFSET_DIN) |-> !pc[0])
		else $error("pc odd on a constant step.");

endmodule

`default_nettype wire

// File: sources.f
source/cpuPkg.sv
source/phaseSequencer.sv
source/jumpGroupDecoder.sv
source/opxMultiplexer.sv
source/programCounter.sv
source/jumpCore.sv
test/jumpCoreTb.sv

// File: test/jumpCoreTb.sv
`default_nettype none
`timescale 1ns/100ps

module jumpCoreTb;

	localparam int NUM_VECTORS = 23;
	localparam int ROW_WORDS   = 7;
	localparam int RESET_CYCLES = 10;
	localparam int CLK_PERIOD  = 8;

	logic CLK;
	logic RESET;
	cpuPkg::instrType   instrIn;
	cpuPkg::flagsType   flags;
	cpuPkg::wordType    din;
	cpuPkg::wordType    regBDout;
	cpuPkg::wordType    pc;
	cpuPkg::phaseType   phase;
	logic [1:0]         addrBusX;
	cpuPkg::regCtrlType regCtrl;
	logic               rdx;

	logic [15:0] vectors [0:NUM_VECTORS*ROW_WORDS-1];

	jumpCore dut0 (
		.CLK      (CLK),
		.RESET    (RESET),
		.instrIn  (instrIn),
		.flags    (flags),
		.din      (din),
		.regBDout (regBDout),
		.pc       (pc),
		.phase    (phase),
		.addrBusX (addrBusX),
		.regCtrl  (regCtrl),
		.rdx      (rdx)
	);

	always #(CLK_PERIOD/2) CLK = ~CLK;

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic checkPc(input string name, input cpuPkg::wordType exp,
		input cpuPkg::wordType act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
			stopRun("pc mismatch.");
		end
	endtask

	task automatic checkLink(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
			stopRun("register enable mismatch.");
		end
	endtask

	task automatic checkRead(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
			stopRun("read strobe mismatch.");
		end
	endtask

	task automatic checkAddr(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
			stopRun("address select mismatch.");
		end
	endtask

	task automatic checkPhase(input cpuPkg::phaseType exp);
		if (exp !== phase) begin
			$display("[ERROR] %0t phase expected %b actual %b", $time, exp, phase);
			stopRun("phase sequence mismatch.");
		end
	endtask

	// all three enables idle.
	task automatic checkIdle();
		checkLink("regCtrl.regAEn", 1'b0, regCtrl.regAEn);
		checkLink("regCtrl.regAWen", 1'b0, regCtrl.regAWen);
		checkLink("regCtrl.regBEn", 1'b0, regCtrl.regBEn);
	endtask

	// skip rule: bit 1 clear jumps always, else flag xor bit 0.
	function automatic logic jumpTaken(input cpuPkg::instrType ins, input cpuPkg::flagsType f);
		logic cond;
		case (ins.ccF)
			2'd0: cond = f.zero;
			2'd1: cond = f.carry;
			2'd2: cond = f.sign;
			default: cond = f.parity;
		endcase
		if (!ins.skipF[1]) begin
			return 1'b1;
		end
		return ins.skipF[0] ? !cond : cond;
	endfunction

	// watchdog sized from the vector count.
	initial begin
		#((NUM_VECTORS * 4 + RESET_CYCLES + 20) * CLK_PERIOD);
		stopRun("watchdog expired, the run did not finish.");
	end

	initial begin
		int unsigned r;
		int base;
		cpuPkg::instrType cur;
		cpuPkg::flagsType curFlags;
		cpuPkg::wordType prevPc;
		logic prevRead;
		logic expLink;
		logic expRead;
		logic [1:0] expAddr;

		void'($urandom(15));
		CLK = 1'b0;
		RESET = 1'b1;
		instrIn = '0;
		flags = '0;
		din = '0;
		regBDout = '0;
		$readmemh("test/jumpTestdata.txt", vectors);

		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		checkPc("pc", 16'h0000, pc);
		checkPhase(cpuPkg::PHASE_FETCH);
		checkRead("rdx", 1'b0, rdx);
		checkIdle();

		prevPc = 16'h0000;
		prevRead = 1'b0;
		for (int i = 0; i < NUM_VECTORS; i++) begin
			base = i * ROW_WORDS;
			r = $urandom;
			cur = vectors[base];
			cur.spare = r[2:0]; // unused bits get noise.
			cur.argB = r[6:3];
			curFlags = vectors[base+1][3:0];
			expLink = vectors[base+5][0];
			expRead = vectors[base+6][0];

			@(posedge CLK); // edge that starts fetch.
			RESET <= 1'b0;
			instrIn <= cur;
			flags <= curFlags;
			din <= vectors[base+2];
			regBDout <= vectors[base+3];

			@(negedge CLK);
			checkPhase(cpuPkg::PHASE_FETCH);
			checkPc("pc", prevPc, pc);
			checkRead("rdx", prevRead, rdx); // tail of the previous strobe.
			checkIdle();

			@(posedge CLK);
			@(negedge CLK);
			checkPhase('{fetch: 1'b0, decode: 1'b1, execute: 1'b0, commit: 1'b0});
			checkRead("rdx", 1'b0, rdx);
			checkIdle();

			@(posedge CLK);
			@(negedge CLK);
			checkPhase('{fetch: 1'b0, decode: 1'b0, execute: 1'b1, commit: 1'b0});
			checkRead("rdx", expRead, rdx);
			checkIdle();

			@(posedge CLK);
			@(negedge CLK);
			checkPhase('{fetch: 1'b0, decode: 1'b0, execute: 1'b0, commit: 1'b1});
			checkRead("rdx", expRead, rdx);
			checkLink("regCtrl.regAWen", expLink, regCtrl.regAWen);
			if (cur.groupF == cpuPkg::GROUP_JUMP) begin
				checkLink("regCtrl.regAEn", expLink, regCtrl.regAEn);
				if (jumpTaken(cur, curFlags) && cur.jpF[1]) begin
					expAddr = cpuPkg::ADDR_HERE;
				end else begin
					expAddr = cpuPkg::ADDR_PC;
				end
			end else begin
				checkIdle(); // no register traffic on a plain step.
				expAddr = cpuPkg::ADDR_PC;
			end
			checkAddr("addrBusX", expAddr, addrBusX);

			prevPc = vectors[base+4];
			prevRead = expRead;
		end

		@(posedge CLK);
		@(negedge CLK);
		checkPhase(cpuPkg::PHASE_FETCH);
		checkPc("pc", prevPc, pc);

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/jumpTestdata.txt
// instr flags(zcsp) din regBDout expPc expLink expRead
// spare and argB bits are zero here and get random fill in the testbench
0000 0 1234 5678 0002 0 0
4000 0 1234 5678 0004 0 0
C000 0 1234 5678 0006 0 0
8000 0 1111 0100 0100 0 0
8180 0 0200 2222 0200 1 0
8200 0 0300 3333 0300 0 1
8380 0 0010 4444 0310 1 1
A000 8 5555 0400 0400 0 0
A000 0 5555 0444 0402 0 0
B000 0 6666 0500 0500 0 0
B000 8 6666 0555 0502 0 0
A600 4 0600 7777 0600 0 1
A600 0 0666 7777 0604 0 1
B780 0 0020 8888 0624 1 1
B780 4 0020 8888 0628 1 1
A900 2 0700 9999 0700 0 0
B900 2 0777 9999 0702 0 0
AC80 1 AAAA 0800 0800 1 0
BE00 1 0888 BBBB 0804 0 1
BE00 0 0900 BBBB 0900 0 1
9300 0 FFF0 CCCC 08F0 0 1
4080 F DDDD EEEE 08F2 0 0
C000 0 DDDD EEEE 08F4 0 0
